// File: hdl/csr_file.sv
`timescale 1ns/1ns

module csr_file (
  input  logic                   clk,
  input  logic                   nrst,
  input  rv_ctrl_pkg::csr_addr_t raddr,
  input  rv_ctrl_pkg::csr_addr_t waddr,
  input  logic                   wen,
  input  rv_types_pkg::word_t    wdata,
  output rv_types_pkg::word_t    rdata
);
  import rv_types_pkg::*;
  import rv_ctrl_pkg::*;

  word_t mscratch;
  word_t mepc;
  word_t mtvec;

  // Unknown addresses read as zero
  always_comb begin
    case (raddr)
      CSR_MSCRATCH: rdata = mscratch;
      CSR_MEPC:     rdata = mepc;
      CSR_MTVEC:    rdata = mtvec;
      default:      rdata = '0;
    endcase
  end

  // mtvec kept whole, no base/mode split
  always_ff @(posedge clk) begin
    if (!nrst) begin
      mscratch <= '0;
      mepc     <= '0;
      mtvec    <= '0;
    end else if (wen) begin
      case (waddr)
        CSR_MSCRATCH: mscratch <= wdata;
        CSR_MEPC:     mepc     <= wdata;
        CSR_MTVEC:    mtvec    <= wdata;
        default: begin
        end
      endcase
    end
  end

  // One op in flight, so a write never repeats on the next cycle
  assert property (@(posedge clk) disable iff (!nrst) wen |=> !wen);

endmodule

// File: hdl/load_extract.sv
`timescale 1ns/1ns

module load_extract (
  input  rv_types_pkg::word_t    load,
  input  logic [1:0]             addr_low,
  input  rv_ctrl_pkg::mem_size_t size,
  input  logic                   is_unsigned,
  output rv_types_pkg::word_t    value
);
  import rv_types_pkg::*;
  import rv_ctrl_pkg::*;

  load_word_u  lanes;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  assign lanes = load;

  // Halfword lane comes from bit 1 only, low offset bit ignored
  assign sel_byte = lanes.bytes[addr_low];
  assign sel_half = lanes.halves[addr_low[1]];

  always_comb begin
    case (size)
      MEM_BYTE: begin
        if (is_unsigned) begin
          value = {24'd0, sel_byte};
        end else begin
          value = {{24{sel_byte[7]}}, sel_byte};
        end
      end
      MEM_HALF: begin
        if (is_unsigned) begin
          value = {16'd0, sel_half};
        end else begin
          value = {{16{sel_half[15]}}, sel_half};
        end
      end
      // Word loads pass through
      default: value = load;
    endcase
  end

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    req,
  output logic                    ack,
  input  rv_types_pkg::word_t     op_alu,
  input  rv_types_pkg::word_t     op_rs2,
  input  rv_types_pkg::word_t     op_rs1_val,
  input  rv_types_pkg::reg_idx_t  op_rs1,
  input  rv_types_pkg::word_t     op_pc,
  input  rv_types_pkg::reg_idx_t  op_rd,
  input  logic                    op_read,
  input  rv_ctrl_pkg::mem_size_t  op_write,
  input  rv_ctrl_pkg::mem_size_t  op_size,
  input  logic                    op_unsigned,
  input  rv_ctrl_pkg::wb_src_t    op_wb_src,
  input  rv_ctrl_pkg::csr_op_t    op_csr_op,
  input  logic                    op_csr_imm,
  input  rv_ctrl_pkg::csr_addr_t  op_csr_addr,
  input  rv_types_pkg::word_t     mem_load,
  input  logic                    mem_ready,
  output rv_types_pkg::word_t     mem_addr,
  output logic                    mem_read,
  output rv_ctrl_pkg::mem_size_t  mem_write,
  output rv_types_pkg::word_t     mem_store,
  output logic                    mem_done,
  output logic                    wb_valid,
  output rv_types_pkg::word_t     wb_alu,
  output rv_types_pkg::word_t     wb_load,
  output rv_types_pkg::word_t     wb_pc,
  output rv_types_pkg::reg_idx_t  wb_rd,
  output rv_types_pkg::reg_idx_t  wb_rs1,
  output rv_types_pkg::word_t     wb_rs1_val,
  output rv_ctrl_pkg::mem_size_t  wb_size,
  output logic                    wb_unsigned,
  output rv_ctrl_pkg::wb_src_t    wb_src,
  output rv_ctrl_pkg::csr_op_t    wb_csr_op,
  output logic                    wb_csr_imm,
  output rv_ctrl_pkg::csr_addr_t  wb_csr_addr
);
  import rv_types_pkg::*;
  import rv_ctrl_pkg::*;

  // FSM state is busy (memory access) and ack (writeback/ack), idle when both are low
  logic       busy;
  logic       start;
  logic       finish;
  logic       access;
  logic       cap_read;
  mem_size_t  cap_write;
  word_t      cap_rs2;
  load_word_u store_lanes;

  assign start  = req & ~busy & ~ack;
  assign access = cap_read | (cap_write != MEM_NONE);
  // Ops without memory access finish on the first busy cycle
  assign finish = busy & (~access | mem_ready);

  assign mem_addr  = wb_alu;
  assign mem_read  = busy & cap_read;
  assign mem_write = busy ? cap_write : MEM_NONE;
  assign mem_done  = busy & access & mem_ready;
  assign mem_store = store_lanes;

  // Place store data into the lanes named by the address offset
  always_comb begin
    case (cap_write)
      MEM_BYTE: begin
        store_lanes = '0;
        store_lanes.bytes[wb_alu[1:0]] = cap_rs2[7:0];
      end
      MEM_HALF: begin
        store_lanes = '0;
        store_lanes.halves[wb_alu[1]] = cap_rs2[15:0];
      end
      default: store_lanes = cap_rs2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      busy      <= 1'b0;
      ack       <= 1'b0;
      wb_valid  <= 1'b0;
      cap_read  <= 1'b0;
      cap_write <= MEM_NONE;
    end else begin
      wb_valid <= finish;
      if (start) begin
        busy      <= 1'b1;
        cap_read  <= op_read;
        cap_write <= op_write;
      end else if (finish) begin
        busy <= 1'b0;
        ack  <= 1'b1;
      end else if (ack && !req) begin
        ack <= 1'b0;
      end
    end
  end

  // Operation fields stay put from capture until the next op
  always_ff @(posedge clk) begin
    if (start) begin
      wb_alu      <= op_alu;
      cap_rs2     <= op_rs2;
      wb_rs1_val  <= op_rs1_val;
      wb_rs1      <= op_rs1;
      wb_pc       <= op_pc;
      wb_rd       <= op_rd;
      wb_size     <= op_size;
      wb_unsigned <= op_unsigned;
      wb_src      <= op_wb_src;
      wb_csr_op   <= op_csr_op;
      wb_csr_imm  <= op_csr_imm;
      wb_csr_addr <= op_csr_addr;
    end
    if (mem_done) begin
      wb_load <= mem_load;
    end
  end

  // Upstream must never hand over an op that both reads and writes
  assert property (@(posedge clk) disable iff (!nrst)
    !(mem_read && (mem_write != MEM_NONE)));

  // Request held steady under back-pressure
  assert property (@(posedge clk) disable iff (!nrst)
    (mem_read || (mem_write != MEM_NONE)) && !mem_ready |=>
      $stable(mem_read) && $stable(mem_write) && $stable(mem_addr) && $stable(mem_store));

endmodule

// File: hdl/mem_wb_top.sv
`timescale 1ns/1ns

module mem_wb_top (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    req,
  output logic                    ack,
  input  rv_types_pkg::word_t     op_alu,
  input  rv_types_pkg::word_t     op_rs2,
  input  rv_types_pkg::word_t     op_rs1_val,
  input  rv_types_pkg::reg_idx_t  op_rs1,
  input  rv_types_pkg::word_t     op_pc,
  input  rv_types_pkg::reg_idx_t  op_rd,
  input  logic                    op_read,
  input  rv_ctrl_pkg::mem_size_t  op_write,
  input  rv_ctrl_pkg::mem_size_t  op_size,
  input  logic                    op_unsigned,
  input  rv_ctrl_pkg::wb_src_t    op_wb_src,
  input  rv_ctrl_pkg::csr_op_t    op_csr_op,
  input  logic                    op_csr_imm,
  input  rv_ctrl_pkg::csr_addr_t  op_csr_addr,
  output rv_types_pkg::word_t     mem_addr,
  output logic                    mem_read,
  output rv_ctrl_pkg::mem_size_t  mem_write,
  output rv_types_pkg::word_t     mem_store,
  input  rv_types_pkg::word_t     mem_load,
  input  logic                    mem_ready,
  output logic                    mem_done,
  output logic                    rf_wen,
  output rv_types_pkg::reg_idx_t  rf_wsel,
  output rv_types_pkg::word_t     rf_wdat
);
  import rv_types_pkg::*;
  import rv_ctrl_pkg::*;

  // Writeback register contents
  logic      wb_valid;
  word_t     wb_alu;
  word_t     wb_load;
  word_t     wb_pc;
  reg_idx_t  wb_rd;
  reg_idx_t  wb_rs1;
  word_t     wb_rs1_val;
  mem_size_t wb_size;
  logic      wb_unsigned;
  wb_src_t   wb_src;
  csr_op_t   wb_csr_op;
  logic      wb_csr_imm;
  csr_addr_t wb_csr_addr;

  // CSR port, one address serves read and write
  csr_addr_t csr_addr;
  logic      csr_wen;
  word_t     csr_wdata;
  word_t     csr_rdata;

  mem_stage mem_stage_inst (.*);

  writeback_stage writeback_stage_inst (.*);

  csr_file csr_file_inst (
    .clk   (clk),
    .nrst  (nrst),
    .raddr (csr_addr),
    .waddr (csr_addr),
    .wen   (csr_wen),
    .wdata (csr_wdata),
    .rdata (csr_rdata)
  );

endmodule

// File: hdl/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  // Access width, doubles as the store lane code on the memory port
  typedef enum logic [1:0] {
    MEM_NONE = 2'd0,
    MEM_BYTE = 2'd1,
    MEM_HALF = 2'd2,
    MEM_WORD = 2'd3
  } mem_size_t;

  // Register writeback source
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2,
    WB_CSR = 2'd3
  } wb_src_t;

  // CSR read-modify-write operation
  typedef enum logic [1:0] {
    CSR_MOVE  = 2'd0,
    CSR_SET   = 2'd1,
    CSR_CLEAR = 2'd2
  } csr_op_t;

  typedef logic [11:0] csr_addr_t;

  // Machine CSRs
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;

  // PC step between instructions
  localparam int INST_BYTES = 4;

endpackage

// File: hdl/rv_types_pkg.sv
package rv_types_pkg;

  // One machine word on every data path
  typedef logic [31:0] word_t;

  // Register file index, also reused as the 5-bit CSR immediate
  typedef logic [4:0] reg_idx_t;

  // A memory word seen as byte lanes or as halfword lanes.
  // Lane 0 is the least significant, so the address offset indexes directly.
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } load_word_u;

endpackage

// File: hdl/writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage (
  input  logic                    wb_valid,
  input  rv_types_pkg::word_t     wb_alu,
  input  rv_types_pkg::word_t     wb_load,
  input  rv_types_pkg::word_t     wb_pc,
  input  rv_types_pkg::reg_idx_t  wb_rd,
  input  rv_types_pkg::reg_idx_t  wb_rs1,
  input  rv_types_pkg::word_t     wb_rs1_val,
  input  rv_ctrl_pkg::mem_size_t  wb_size,
  input  logic                    wb_unsigned,
  input  rv_ctrl_pkg::wb_src_t    wb_src,
  input  rv_ctrl_pkg::csr_op_t    wb_csr_op,
  input  logic                    wb_csr_imm,
  input  rv_ctrl_pkg::csr_addr_t  wb_csr_addr,
  input  rv_types_pkg::word_t     csr_rdata,
  output logic                    rf_wen,
  output rv_types_pkg::reg_idx_t  rf_wsel,
  output rv_types_pkg::word_t     rf_wdat,
  output rv_ctrl_pkg::csr_addr_t  csr_addr,
  output logic                    csr_wen,
  output rv_types_pkg::word_t     csr_wdata
);
  import rv_types_pkg::*;
  import rv_ctrl_pkg::*;

  word_t load_value;
  word_t csr_src;

  load_extract load_extract_inst (
    .load        (wb_load),
    .addr_low    (wb_alu[1:0]),
    .size        (wb_size),
    .is_unsigned (wb_unsigned),
    .value       (load_value)
  );

  assign rf_wen   = wb_valid;
  assign rf_wsel  = wb_rd;
  assign csr_addr = wb_csr_addr;
  assign csr_wen  = wb_valid & (wb_src == WB_CSR);

  // Immediate form uses the rs1 field itself, zero extended
  assign csr_src = wb_csr_imm ? {27'd0, wb_rs1} : wb_rs1_val;

  always_comb begin
    case (wb_src)
      WB_MEM:  rf_wdat = load_value;
      WB_PC4:  rf_wdat = wb_pc + word_t'(INST_BYTES);
      WB_CSR:  rf_wdat = csr_rdata;
      default: rf_wdat = wb_alu;
    endcase
  end

  // New CSR value from the old one
  always_comb begin
    case (wb_csr_op)
      CSR_MOVE:  csr_wdata = csr_src;
      CSR_SET:   csr_wdata = csr_rdata | csr_src;
      CSR_CLEAR: csr_wdata = csr_rdata & ~csr_src;
      default:   csr_wdata = csr_rdata;
    endcase
  end

endmodule

// File: mem_wb.f
hdl/rv_types_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/load_extract.sv
hdl/csr_file.sv
hdl/writeback_stage.sv
hdl/mem_stage.sv
hdl/mem_wb_top.sv
test/clock_gen.sv
test/mem_wb_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_wb.f --top-module mem_wb_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/Vmem_wb_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi
exit 0

// File: test/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
  output logic clk,
  output logic nrst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held over the first 16 rising edges
  initial begin
    nrst = 1'b0;
    repeat (16) @(posedge clk);
    #1 nrst = 1'b1;
  end

endmodule

// File: test/mem_wb_tb.sv
`timescale 1ns/1ns

module mem_wb_tb;
  import rv_types_pkg::*;
  import rv_ctrl_pkg::*;

  // One table row holds op fields and expected results
  typedef struct packed {
    word_t     alu;
    word_t     rs2;
    word_t     rs1_val;
    reg_idx_t  rs1;
    word_t     pc;
    reg_idx_t  rd;
    logic      read;
    mem_size_t write;
    mem_size_t size;
    logic      uns;
    wb_src_t   src;
    csr_op_t   csr_op;
    logic      csr_imm;
    csr_addr_t csr_addr;
    word_t     exp_wdat;
    word_t     exp_store;
  } op_row_t;

  localparam int WAIT_LIMIT = 50;
  localparam csr_addr_t CSR_LIST [3] = '{CSR_MSCRATCH, CSR_MEPC, CSR_MTVEC};
  localparam csr_op_t OP_SEQ [7] = '{CSR_MOVE, CSR_SET, CSR_CLEAR, CSR_SET,
                                     CSR_CLEAR, CSR_MOVE, CSR_MOVE};
  // Immediate form per step with step 0 in bit 0
  localparam logic [6:0] IMM_SEQ = 7'b0110010;

  logic     clk;
  logic     nrst;
  logic     req;
  logic     ack;
  word_t    mem_addr;
  logic     mem_read;
  mem_size_t mem_write;
  word_t    mem_store;
  word_t    mem_load;
  logic     mem_ready;
  logic     mem_done;
  logic     rf_wen;
  reg_idx_t rf_wsel;
  word_t    rf_wdat;

  op_row_t  drv;
  op_row_t  rows [$];
  word_t    mem [16];
  int       cur = 0;
  int       wen_count = 0;

  clock_gen clock_gen_inst (
    .clk  (clk),
    .nrst (nrst)
  );

  mem_wb_top mem_wb_top_inst (
    .clk         (clk),
    .nrst        (nrst),
    .req         (req),
    .ack         (ack),
    .op_alu      (drv.alu),
    .op_rs2      (drv.rs2),
    .op_rs1_val  (drv.rs1_val),
    .op_rs1      (drv.rs1),
    .op_pc       (drv.pc),
    .op_rd       (drv.rd),
    .op_read     (drv.read),
    .op_write    (drv.write),
    .op_size     (drv.size),
    .op_unsigned (drv.uns),
    .op_wb_src   (drv.src),
    .op_csr_op   (drv.csr_op),
    .op_csr_imm  (drv.csr_imm),
    .op_csr_addr (drv.csr_addr),
    .mem_addr    (mem_addr),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .mem_store   (mem_store),
    .mem_load    (mem_load),
    .mem_ready   (mem_ready),
    .mem_done    (mem_done),
    .rf_wen      (rf_wen),
    .rf_wsel     (rf_wsel),
    .rf_wdat     (rf_wdat)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run("Result check failed");
    end
  endtask

  // Every byte keeps its top bit set
  function automatic word_t fill_word(input int idx);
    return 32'h8090_a0b0 ^ (32'h0101_0101 * idx);
  endfunction

  // Expected load value by width, offset and signedness
  function automatic word_t extend(input word_t w, input int off, input mem_size_t size,
                                   input logic uns);
    word_t v;
    if (size == MEM_BYTE) begin
      v = (w >> (8 * off)) & 32'hff;
      if (!uns && v[7]) begin
        v = v | 32'hffff_ff00;
      end
    end else if (size == MEM_HALF) begin
      v = (w >> (16 * (off / 2))) & 32'hffff;
      if (!uns && v[15]) begin
        v = v | 32'hffff_0000;
      end
    end else begin
      v = w;
    end
    return v;
  endfunction

  function automatic op_row_t new_op(input wb_src_t src, input word_t alu, input word_t expv);
    op_row_t r;
    r = '0;
    r.src = src;
    r.alu = alu;
    r.rd = reg_idx_t'(rows.size() % 31 + 1);
    r.exp_wdat = expv;
    return r;
  endfunction

  // Full four-phase handshake for one row
  task automatic run_op(input op_row_t r);
    int t;
    int wen_before;
    wen_before = wen_count;
    drv = r;
    req = 1'b1;
    t = 0;
    while (!ack) begin
      @(posedge clk);
      #1;
      t++;
      if (t > WAIT_LIMIT) begin
        abort_run("Timeout waiting for ack to rise");
      end
    end
    // Writeback pulse shares its cycle with the rising ack
    check_value("rf_wen", 32'(rf_wen), 32'd1);
    check_value("rf_wsel", 32'(rf_wsel), 32'(r.rd));
    check_value("rf_wdat", rf_wdat, r.exp_wdat);
    req = 1'b0;
    t = 0;
    while (ack) begin
      @(posedge clk);
      #1;
      t++;
      if (t > WAIT_LIMIT) begin
        abort_run("Timeout waiting for ack to fall");
      end
    end
    check_value("rf_wen pulse count", wen_count - wen_before, 32'd1);
  endtask

  // Memory model raises ready after 0 to 3 idle cycles
  initial begin : mem_model
    integer    seed;
    int        delay;
    int        i;
    int        b;
    logic      pending;
    mem_size_t w_code;
    word_t     w_addr;
    word_t     w_data;
    seed = 32'hebf0582c;
    delay = 0;
    pending = 1'b0;
    w_code = MEM_NONE;
    w_addr = '0;
    w_data = '0;
    mem_ready = 1'b0;
    mem_load = '0;
    for (i = 0; i < 16; i++) begin
      mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk);
      #1;
      if (mem_ready) begin
        // Store lanes commit on the edge that completes the access
        for (b = 0; b < 4; b++) begin
          if (w_code == MEM_WORD || (w_code == MEM_BYTE && b == int'(w_addr[1:0])) ||
              (w_code == MEM_HALF && b / 2 == int'(w_addr[1]))) begin
            mem[w_addr[5:2]][8 * b +: 8] = w_data[8 * b +: 8];
          end
        end
        mem_ready = 1'b0;
      end else if (mem_read || mem_write != MEM_NONE) begin
        if (!pending) begin
          pending = 1'b1;
          delay = $random(seed) & 3;
        end
        if (delay == 0) begin
          pending = 1'b0;
          w_code = mem_write;
          w_addr = mem_addr;
          w_data = mem_store;
          mem_load = mem[mem_addr[5:2]];
          mem_ready = 1'b1;
        end else begin
          delay--;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (nrst) begin
      if (mem_done && !mem_ready) begin
        abort_run("mem_done went high without mem_ready");
      end
      if (rf_wen) begin
        wen_count++;
      end
      // Request as seen in the completing cycle
      if (mem_ready) begin
        check_value("mem_done", 32'(mem_done), 32'd1);
        check_value("mem_addr", mem_addr, rows[cur].alu);
        check_value("mem_read", 32'(mem_read), 32'(rows[cur].read));
        check_value("mem_write", 32'(mem_write), 32'(rows[cur].write));
        if (rows[cur].write != MEM_NONE) begin
          check_value("mem_store", mem_store, rows[cur].exp_store);
        end
      end
    end
  end

  initial begin : stimulus
    op_row_t r;
    word_t   model;
    word_t   src;
    int      k;
    int      c;
    int      s;
    int      t;
    req = 1'b0;
    drv = '0;

    // Unknown CSR reads zero and ignores the write
    for (k = 0; k < 2; k++) begin
      r = new_op(WB_CSR, 32'd0, 32'd0);
      r.csr_addr = 12'h7c0;
      r.rs1_val = 32'hffff_ffff;
      rows.push_back(r);
    end
    rows.push_back(new_op(WB_ALU, 32'h1357_9bdf, 32'h1357_9bdf));
    r = new_op(WB_PC4, 32'd0, 32'h0000_1000);
    r.pc = 32'h0000_0ffc;
    rows.push_back(r);

    // Byte stores build word 8 and halfword stores build word 9
    for (k = 0; k < 4; k++) begin
      r = new_op(WB_ALU, 32'd32 + k, 32'd32 + k);
      r.write = MEM_BYTE;
      r.rs2 = 32'hdead_be00 | (32'h11 * (k + 1));
      r.exp_store = (32'h11 * (k + 1)) << (8 * k);
      rows.push_back(r);
    end
    for (k = 0; k < 4; k += 2) begin
      r = new_op(WB_ALU, 32'd36 + k, 32'd36 + k);
      r.write = MEM_HALF;
      r.rs2 = {16'hbeef, (k == 0) ? 16'h5566 : 16'h7788};
      r.exp_store = {16'h0, r.rs2[15:0]} << (8 * k);
      rows.push_back(r);
    end
    r = new_op(WB_ALU, 32'd40, 32'd40);
    r.write = MEM_WORD;
    r.rs2 = 32'hcafe_f00d;
    r.exp_store = 32'hcafe_f00d;
    rows.push_back(r);

    // Read the stored words back
    for (k = 0; k < 3; k++) begin
      r = new_op(WB_MEM, 32'd32 + 4 * k, (k == 0) ? 32'h4433_2211 :
                 (k == 1) ? 32'h7788_5566 : 32'hcafe_f00d);
      r.read = 1'b1;
      r.size = MEM_WORD;
      rows.push_back(r);
    end

    // Loads from preloaded words 3 and 5 with signed ones first
    for (k = 0; k < 8; k++) begin
      r = new_op(WB_MEM, 32'd12 + k % 4, extend(fill_word(3), k % 4, MEM_BYTE, k >= 4));
      r.read = 1'b1;
      r.size = MEM_BYTE;
      r.uns = (k >= 4);
      rows.push_back(r);
    end
    for (k = 0; k < 4; k++) begin
      r = new_op(WB_MEM, 32'd20 + (k % 2) * 2,
                 extend(fill_word(5), (k % 2) * 2, MEM_HALF, k >= 2));
      r.read = 1'b1;
      r.size = MEM_HALF;
      r.uns = (k >= 2);
      rows.push_back(r);
    end
    r = new_op(WB_MEM, 32'd20, fill_word(5));
    r.read = 1'b1;
    r.size = MEM_WORD;
    rows.push_back(r);

    // In each CSR chain an op returns the value left by the one before
    for (c = 0; c < 3; c++) begin
      model = '0;
      for (s = 0; s < 7; s++) begin
        r = new_op(WB_CSR, 32'd0, model);
        r.csr_addr = CSR_LIST[c];
        r.csr_op = OP_SEQ[s];
        r.csr_imm = IMM_SEQ[s];
        r.rs1 = reg_idx_t'(s + 3 * c + 1);
        r.rs1_val = 32'h5a3c_0f96 ^ (32'h1111_1111 * (s + 1 + 7 * c));
        src = r.csr_imm ? {27'd0, r.rs1} : r.rs1_val;
        case (r.csr_op)
          CSR_MOVE: model = src;
          CSR_SET:  model = model | src;
          default:  model = model & ~src;
        endcase
        rows.push_back(r);
      end
    end

    t = 0;
    while (!nrst) begin
      @(negedge clk);
      t++;
      if (t > 40) begin
        abort_run("Reset was never released");
      end
    end
    @(posedge clk);
    #1;
    check_value("ack", 32'(ack), 32'd0);
    check_value("rf_wen", 32'(rf_wen), 32'd0);
    check_value("mem_read", 32'(mem_read), 32'd0);
    check_value("mem_write", 32'(mem_write), 32'(MEM_NONE));
    check_value("mem_done", 32'(mem_done), 32'd0);

    for (k = 0; k < rows.size(); k++) begin
      cur = k;
      run_op(rows[k]);
    end
    $display("all tests passed");
    $finish;
  end

endmodule
